// ==== list.f ====
cache_pkg.sv
cache_ctrl_if.sv
cache_req_in.sv
cache_ctrl.sv
cache_arrays.sv
cache_mem_out.sv
cache_top.sv
cache_tb_mem.sv
cache_tb.sv

// ==== Bender.yml ====
package:
  name: dm_wb_cache

sources:
  - files:
      - cache_pkg.sv
      - cache_ctrl_if.sv
      - cache_req_in.sv
      - cache_ctrl.sv
      - cache_arrays.sv
      - cache_mem_out.sv
      - cache_top.sv
  - target: test
    files:
      - cache_tb_mem.sv
      - cache_tb.sv

// ==== cache_tb.sv ====
// Testbench for the direct-mapped write-back cache
// LCG-driven requests checked against a word-level reference model
`timescale 1ns/100ps
`default_nettype none

module cache_tb;

  localparam int num_lines    = 16;
  localparam int model_words  = 256;
  localparam int init_words   = 64;
  localparam int rand_count   = 400;
  localparam int sweep_count  = 2 * num_lines;
  localparam int req_count    = 2 * init_words + rand_count + sweep_count;
  localparam int cycle_budget = 60 * req_count;

  logic                               clk;
  logic                               reset;
  logic                               cachereq_val;
  logic                               cachereq_rdy;
  logic [2:0]                         cachereq_type;
  logic [cache_pkg::opaque_nbits-1:0] cachereq_opaque;
  logic [cache_pkg::addr_nbits-1:0]   cachereq_addr;
  logic [cache_pkg::data_nbits-1:0]   cachereq_data;
  logic                               cacheresp_val;
  logic                               cacheresp_rdy;
  logic [2:0]                         cacheresp_type;
  logic [cache_pkg::opaque_nbits-1:0] cacheresp_opaque;
  logic [cache_pkg::data_nbits-1:0]   cacheresp_data;
  logic                               memreq_val;
  logic                               memreq_rdy;
  logic                               memreq_type;
  logic [cache_pkg::addr_nbits-1:0]   memreq_addr;
  logic [cache_pkg::line_nbits-1:0]   memreq_data;
  logic                               memresp_val;
  logic                               memresp_rdy;
  logic                               memresp_type;
  logic [cache_pkg::line_nbits-1:0]   memresp_data;

  logic [31:0]                        model [model_words];
  logic [31:0]                        rand_state;
  logic [cache_pkg::opaque_nbits-1:0] opaque_ctr;
  logic                               quiet_mem;

  cache_top #(.num_lines(num_lines)) DUT (.*);

  cache_tb_mem #(.seed(32'h1fdd)) mem (.*);

  always #10 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------

  function automatic logic [31:0] lcg_step();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rand_state[31:8]};
  endfunction

  // Preload pattern, shared by model and memory store
  function automatic logic [31:0] init_word(input int word_idx);
    return (32'(word_idx) * 32'h9e37_79b1) ^ 32'h0bad_f00d;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_resp(input cache_pkg::cache_resp_t got,
                            input cache_pkg::cache_resp_t exp);
    string msg;
    if (got !== exp) begin
      msg = $sformatf("Error at %0d ns: response type %0d opaque %h data %h,",
                      $time, got.msg_type, got.opaque, got.data);
      msg = {msg, $sformatf(" expected type %0d opaque %h data %h",
                            exp.msg_type, exp.opaque, exp.data)};
      abort_run(msg);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("Error at %0d ns: hit response after %0d cycles, expected %0d",
                          $time, got, exp));
    end
  endtask

  task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0d ns: memory word %h holds %h, expected %h",
                          $time, addr, got, exp));
    end
  endtask

  // One request, then wait for its response; latency counts cycles from acceptance
  task automatic send_request(input cache_pkg::req_type_t kind, input logic [31:0] addr,
                              input logic [31:0] data, input bit rdy_always,
                              output cache_pkg::cache_resp_t resp, output int latency);
    bit taken;
    @(negedge clk);
    if (cacheresp_val) abort_run("Response appeared with no request pending");
    cachereq_val    = 1'b1;
    cachereq_type   = kind;
    cachereq_opaque = opaque_ctr;
    cachereq_addr   = addr;
    cachereq_data   = data;
    while (!cachereq_rdy) @(negedge clk);
    latency = 0;
    taken   = 1'b0;
    while (!taken) begin
      @(negedge clk);
      latency++;
      cachereq_val  = 1'b0;
      cachereq_addr = lcg_step();
      cachereq_data = lcg_step();
      cacheresp_rdy = rdy_always || (lcg_step() % 3 != 0);
      if (cachereq_rdy) abort_run("Request port ready while a response is pending");
      if (cacheresp_val && cacheresp_rdy) begin
        resp  = {cacheresp_type, cacheresp_opaque, cacheresp_data};
        taken = 1'b1;
      end
    end
    @(posedge clk);
  endtask

  task automatic issue_and_check(input cache_pkg::req_type_t kind, input int word_idx,
                                 input logic [31:0] data, input bit rdy_always,
                                 output int latency);
    cache_pkg::cache_resp_t exp;
    cache_pkg::cache_resp_t got;
    exp.msg_type = kind;
    exp.opaque   = opaque_ctr;
    exp.data     = (kind == cache_pkg::req_read) ? model[word_idx] : '0;
    send_request(kind, 32'(word_idx) << 2, data, rdy_always, got, latency);
    check_resp(got, exp);
    if (kind != cache_pkg::req_read) begin
      model[word_idx] = data;
    end
    opaque_ctr++;
  endtask

  // No memory traffic while lines are only being initialized or hit
  always @(negedge clk) begin
    if (quiet_mem && memreq_val) abort_run("Memory request during the init or read-hit phase");
  end

  initial begin
    repeat (cycle_budget) @(posedge clk);
    abort_run($sformatf("Timeout: run did not finish within %0d cycles", cycle_budget));
  end

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    int latency;
    int idx;
    cache_pkg::req_type_t kind;
    clk             = 1'b0;
    reset           = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = '0;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cacheresp_rdy   = 1'b0;
    quiet_mem       = 1'b0;
    opaque_ctr      = '0;
    rand_state      = 32'h1fdd;
    for (int i = 0; i < model_words; i++) begin
      model[i]     = init_word(i);
      mem.store[i] = init_word(i);
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (cachereq_rdy !== 1'b1 || cacheresp_val !== 1'b0 || memreq_val !== 1'b0 ||
        memresp_rdy !== 1'b0) begin
      abort_run("Handshake outputs not in their idle state after reset");
    end

    // Init every word of the first 256 bytes, then read them back as hits
    quiet_mem = 1'b1;
    for (int i = 0; i < init_words; i++) begin
      issue_and_check(cache_pkg::req_init, i, init_word(i), 1'b1, latency);
    end
    for (int i = 0; i < init_words; i++) begin
      issue_and_check(cache_pkg::req_read, i, '0, 1'b1, latency);
      check_latency(latency, 3);
    end
    quiet_mem = 1'b0;

    // Random reads and writes over 1 KB with random back-pressure
    for (int n = 0; n < rand_count; n++) begin
      idx  = lcg_step() % model_words;
      kind = (lcg_step() % 2 != 0) ? cache_pkg::req_write : cache_pkg::req_read;
      issue_and_check(kind, idx, lcg_step(), 1'b0, latency);
    end

    // Two tags per index push every dirty line out
    for (int i = 0; i < num_lines; i++) begin
      issue_and_check(cache_pkg::req_read, 4 * i, '0, 1'b0, latency);
      issue_and_check(cache_pkg::req_read, 4 * (num_lines + i), '0, 1'b0, latency);
    end

    for (int i = 0; i < model_words; i++) begin
      check_word(32'(i) << 2, mem.store[i], model[i]);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_tb_mem.sv ====
// Memory model for the cache testbench
// Line-wide val/rdy responder with random stalls over a 1 KB word store
`timescale 1ns/100ps
`default_nettype none

module cache_tb_mem #(
  parameter logic [31:0] seed = 32'h1fdd
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             memreq_val,
  output logic                             memreq_rdy,
  input  logic                             memreq_type,
  input  logic [cache_pkg::addr_nbits-1:0] memreq_addr,
  input  logic [cache_pkg::line_nbits-1:0] memreq_data,
  output logic                             memresp_val,
  input  logic                             memresp_rdy,
  output logic                             memresp_type,
  output logic [cache_pkg::line_nbits-1:0] memresp_data
);

  // Backing store of 32-bit words filled by the testbench
  logic [31:0]                      store [256];
  logic [31:0]                      rand_state;
  logic                             in_reset;
  logic                             req_seen;
  logic                             resp_seen;
  logic                             busy;
  logic                             held_type;
  logic [cache_pkg::addr_nbits-1:0] held_addr;
  logic [cache_pkg::line_nbits-1:0] held_data;
  int                               delay;
  int                               line_idx;

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return {8'h00, rand_state[31:8]};
  endfunction

  initial begin
    rand_state   = seed;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_type = 1'b0;
    memresp_data = '0;
    req_seen     = 1'b0;
    resp_seen    = 1'b0;
    busy         = 1'b0;
    delay        = 0;
  end

  // Reset as the DUT sees it on the rising edge
  always @(posedge clk) begin
    in_reset <= reset;
  end

  // Everything else runs on the falling edge and a val/rdy pair seen
  // here completes on the next rising edge
  always @(negedge clk) begin
    if (in_reset !== 1'b0) begin
      memreq_rdy  = 1'b0;
      memresp_val = 1'b0;
      req_seen    = 1'b0;
      resp_seen   = 1'b0;
      busy        = 1'b0;
    end else begin
      if (resp_seen) begin
        memresp_val = 1'b0;
        resp_seen   = 1'b0;
        busy        = 1'b0;
      end
      if (req_seen) begin
        line_idx = int'(held_addr[9:4]);
        memresp_type = held_type;
        memresp_data = '0;
        for (int w = 0; w < 4; w++) begin
          if (held_type == cache_pkg::mem_write) begin
            store[4*line_idx + w] = held_data[32*w +: 32];
          end else begin
            memresp_data[32*w +: 32] = store[4*line_idx + w];
          end
        end
        memreq_rdy = 1'b0;
        req_seen   = 1'b0;
        busy       = 1'b1;
        delay      = next_rand() % 4;
      end else if (!busy) begin
        memreq_rdy = (next_rand() % 3) != 0;
      end
      if (busy && !memresp_val) begin
        if (delay == 0) begin
          memresp_val = 1'b1;
        end else begin
          delay--;
        end
      end
      if (memreq_val && memreq_rdy) begin
        held_type = memreq_type;
        held_addr = memreq_addr;
        held_data = memreq_data;
        req_seen  = 1'b1;
      end
      if (memresp_val && memresp_rdy) begin
        resp_seen = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
// Blocking direct-mapped write-back cache, top level
// Request stage, controller, arrays and output stage on flat val/rdy ports
`timescale 1ns/100ps
`default_nettype none

module cache_top #(
  parameter int num_lines = 16
) (
  input  logic                               clk,
  input  logic                               reset,

  // Processor request
  input  logic                               cachereq_val,
  output logic                               cachereq_rdy,
  input  logic [2:0]                         cachereq_type,
  input  logic [cache_pkg::opaque_nbits-1:0] cachereq_opaque,
  input  logic [cache_pkg::addr_nbits-1:0]   cachereq_addr,
  input  logic [cache_pkg::data_nbits-1:0]   cachereq_data,

  // Processor response
  output logic                               cacheresp_val,
  input  logic                               cacheresp_rdy,
  output logic [2:0]                         cacheresp_type,
  output logic [cache_pkg::opaque_nbits-1:0] cacheresp_opaque,
  output logic [cache_pkg::data_nbits-1:0]   cacheresp_data,

  // Memory request
  output logic                               memreq_val,
  input  logic                               memreq_rdy,
  output logic                               memreq_type,
  output logic [cache_pkg::addr_nbits-1:0]   memreq_addr,
  output logic [cache_pkg::line_nbits-1:0]   memreq_data,

  // Memory response
  input  logic                               memresp_val,
  output logic                               memresp_rdy,
  input  logic                               memresp_type,
  input  logic [cache_pkg::line_nbits-1:0]   memresp_data
);

  localparam int tag_nbits = cache_pkg::addr_nbits - cache_pkg::offset_nbits
                             - $clog2(num_lines);

  cache_pkg::cache_req_t            cachereq;
  cache_pkg::cache_req_t            req_reg;
  cache_pkg::cache_resp_t           cacheresp;
  cache_pkg::mem_req_t              memreq;
  cache_pkg::mem_resp_t             memresp;
  logic [15:0]                      wben;
  logic [cache_pkg::line_nbits-1:0] read_line;
  logic [cache_pkg::line_nbits-1:0] refill_line;
  logic [tag_nbits-1:0]             victim_tag;

  // Flat ports to and from message structs
  assign cachereq         = {cachereq_type, cachereq_opaque, cachereq_addr, cachereq_data};
  assign memresp          = {memresp_type, memresp_data};
  assign cacheresp_type   = cacheresp.msg_type;
  assign cacheresp_opaque = cacheresp.opaque;
  assign cacheresp_data   = cacheresp.data;
  assign memreq_type      = memreq.msg_type;
  assign memreq_addr      = memreq.addr;
  assign memreq_data      = memreq.data;

  cache_ctrl_if #(.num_lines(num_lines)) ctrl_bus ();

  cache_req_in #(.num_lines(num_lines)) u_req_in (
    .clk      (clk),
    .reset    (reset),
    .cachereq (cachereq),
    .ctrl     (ctrl_bus.dpath),
    .req_reg  (req_reg),
    .wben     (wben)
  );

  cache_ctrl #(.num_lines(num_lines)) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .ctrl          (ctrl_bus.ctrl)
  );

  cache_arrays #(.num_lines(num_lines)) u_arrays (
    .clk         (clk),
    .ctrl        (ctrl_bus.dpath),
    .req_reg     (req_reg),
    .wben        (wben),
    .refill_line (refill_line),
    .read_line   (read_line),
    .victim_tag  (victim_tag)
  );

  cache_mem_out #(.num_lines(num_lines)) u_mem_out (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl_bus.dpath),
    .req_reg     (req_reg),
    .read_line   (read_line),
    .victim_tag  (victim_tag),
    .memresp     (memresp),
    .memreq      (memreq),
    .refill_line (refill_line),
    .cacheresp   (cacheresp)
  );

endmodule

`default_nettype wire

// ==== cache_mem_out.sv ====
// Cache output stage
// Builds memory requests, captures refill lines, registers the response
`timescale 1ns/100ps
`default_nettype none

module cache_mem_out #(
  parameter  int num_lines   = 16,
  localparam int index_nbits = $clog2(num_lines),
  localparam int tag_nbits   = cache_pkg::addr_nbits - cache_pkg::offset_nbits - index_nbits
) (
  input  logic                             clk,
  input  logic                             reset,
  cache_ctrl_if.dpath                      ctrl,
  input  cache_pkg::cache_req_t            req_reg,
  input  logic [cache_pkg::line_nbits-1:0] read_line,
  input  logic [tag_nbits-1:0]             victim_tag,
  input  cache_pkg::mem_resp_t             memresp,
  output cache_pkg::mem_req_t              memreq,
  output logic [cache_pkg::line_nbits-1:0] refill_line,
  output cache_pkg::cache_resp_t           cacheresp
);

  logic [cache_pkg::addr_nbits-1:0] evict_addr;
  logic [cache_pkg::data_nbits-1:0] req_word;

  // Victim line address from stored tag and request index
  always_ff @(posedge clk) begin
    if (ctrl.evict_addr_en) begin
      evict_addr <= {victim_tag, ctrl.req_index, {cache_pkg::offset_nbits{1'b0}}};
    end
  end

  assign memreq.msg_type = ctrl.mem_type;
  assign memreq.addr     = (ctrl.memreq_addr_sel == cache_pkg::sel_evict_addr) ?
                           evict_addr : cache_pkg::line_base(req_reg.addr);
  // Read line stays put until the next array read, so eviction data is stable
  assign memreq.data     = read_line;

  always_ff @(posedge clk) begin
    if (ctrl.refill_en) begin
      refill_line <= memresp.data;
    end
  end

  assign req_word = read_line[cache_pkg::data_nbits*cache_pkg::word_sel(req_reg.addr) +:
                              cache_pkg::data_nbits];

  // Writes and inits answer with zero data
  always_ff @(posedge clk) begin
    if (reset) begin
      cacheresp <= '0;
    end else if (ctrl.resp_en) begin
      cacheresp.msg_type <= req_reg.msg_type;
      cacheresp.opaque   <= req_reg.opaque;
      cacheresp.data     <= (req_reg.msg_type == cache_pkg::req_read) ? req_word : '0;
    end
  end

endmodule

`default_nettype wire

// ==== cache_arrays.sv ====
// Tag and data arrays of the direct-mapped cache
// Synchronous reads, tag compare, byte-merged word writes and line refills
`timescale 1ns/100ps
`default_nettype none

module cache_arrays #(
  parameter  int num_lines   = 16,
  localparam int index_nbits = $clog2(num_lines),
  localparam int tag_nbits   = cache_pkg::addr_nbits - cache_pkg::offset_nbits - index_nbits
) (
  input  logic                             clk,
  cache_ctrl_if.dpath                      ctrl,
  input  cache_pkg::cache_req_t            req_reg,
  input  logic [15:0]                      wben,
  input  logic [cache_pkg::line_nbits-1:0] refill_line,
  output logic [cache_pkg::line_nbits-1:0] read_line,
  output logic [tag_nbits-1:0]             victim_tag
);

  logic [tag_nbits-1:0]             tag_mem  [num_lines];
  logic [cache_pkg::line_nbits-1:0] data_mem [num_lines];
  logic [tag_nbits-1:0]             req_tag;
  logic [cache_pkg::line_nbits-1:0] write_line;
  logic [cache_pkg::line_bytes-1:0] byte_en;

  assign req_tag = req_reg.addr[cache_pkg::addr_nbits-1 -: tag_nbits];

  // Registered tag output is also the victim tag on a miss
  assign ctrl.tag_match = (victim_tag == req_tag);

  always_ff @(posedge clk) begin
    if (ctrl.tag_wen) begin
      tag_mem[ctrl.req_index] <= req_tag;
    end
    if (ctrl.tag_ren) begin
      victim_tag <= tag_mem[ctrl.req_index];
    end
  end

  // Request word copied to every slot, wben keeps only the addressed one
  assign write_line = (ctrl.write_sel == cache_pkg::sel_refill) ?
                      refill_line : {cache_pkg::line_words{req_reg.data}};
  assign byte_en    = (ctrl.write_sel == cache_pkg::sel_refill) ? '1 : wben;

  always_ff @(posedge clk) begin
    if (ctrl.data_wen) begin
      for (int i = 0; i < cache_pkg::line_bytes; i++) begin
        if (byte_en[i]) begin
          data_mem[ctrl.req_index][8*i +: 8] <= write_line[8*i +: 8];
        end
      end
    end
    if (ctrl.data_ren) begin
      read_line <= data_mem[ctrl.req_index];
    end
  end

endmodule

`default_nettype wire

// ==== cache_ctrl.sv ====
// Blocking cache controller FSM
// Tracks valid and dirty per line, sequences hits, evictions and refills
`timescale 1ns/100ps
`default_nettype none

module cache_ctrl #(
  parameter int num_lines = 16
) (
  input  logic       clk,
  input  logic       reset,

  input  logic       cachereq_val,
  output logic       cachereq_rdy,
  output logic       cacheresp_val,
  input  logic       cacheresp_rdy,

  output logic       memreq_val,
  input  logic       memreq_rdy,
  input  logic       memresp_val,
  output logic       memresp_rdy,

  cache_ctrl_if.ctrl ctrl
);

  localparam int index_nbits = $clog2(num_lines);

  typedef enum logic [3:0] {
    s_idle,
    s_tag_check,
    s_access,
    s_wait,
    s_evict_prepare,
    s_evict_request,
    s_evict_wait,
    s_refill_request,
    s_refill_wait,
    s_refill_update
  } state_t;

  state_t                 state;
  state_t                 state_next;
  logic [num_lines-1:0]   valid_bits;
  logic [num_lines-1:0]   dirty_bits;
  logic [index_nbits-1:0] idx;
  logic                   line_valid;
  logic                   line_dirty;
  logic                   hit;
  logic                   is_init;
  logic                   is_write;
  logic                   set_valid;
  logic                   set_dirty;
  logic                   clear_dirty;

  assign idx        = ctrl.req_index;
  assign line_valid = valid_bits[idx];
  assign line_dirty = dirty_bits[idx];
  assign hit        = line_valid && ctrl.tag_match;
  assign is_init    = (ctrl.req_type == cache_pkg::req_init);
  assign is_write   = (ctrl.req_type == cache_pkg::req_write);

  // ------------------------------
  // State register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      s_idle:           if (cachereq_val) state_next = s_tag_check;
      s_tag_check:      state_next = s_access;
      s_access: begin
        if (is_init || hit) begin
          state_next = s_wait;
        end else if (line_valid && line_dirty) begin
          state_next = s_evict_prepare;
        end else begin
          state_next = s_refill_request;
        end
      end
      s_wait:           if (cacheresp_rdy) state_next = s_idle;
      s_evict_prepare:  state_next = s_evict_request;
      s_evict_request:  if (memreq_rdy) state_next = s_evict_wait;
      s_evict_wait:     if (memresp_val) state_next = s_refill_request;
      s_refill_request: if (memreq_rdy) state_next = s_refill_wait;
      s_refill_wait:    if (memresp_val) state_next = s_refill_update;
      // Replay the access against the fresh line
      s_refill_update:  state_next = s_tag_check;
      default:          state_next = s_idle;
    endcase
  end

  // ------------------------------
  // Handshakes and strobes
  // ------------------------------

  always_comb begin
    cachereq_rdy         = 1'b0;
    cacheresp_val        = 1'b0;
    memreq_val           = 1'b0;
    memresp_rdy          = 1'b0;
    ctrl.req_en          = 1'b0;
    ctrl.tag_ren         = 1'b0;
    ctrl.tag_wen         = 1'b0;
    ctrl.data_ren        = 1'b0;
    ctrl.data_wen        = 1'b0;
    ctrl.write_sel       = cache_pkg::sel_req_word;
    ctrl.evict_addr_en   = 1'b0;
    ctrl.memreq_addr_sel = cache_pkg::sel_refill_addr;
    ctrl.refill_en       = 1'b0;
    ctrl.resp_en         = 1'b0;
    ctrl.mem_type        = cache_pkg::mem_read;
    case (state)
      s_idle: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = cachereq_val;
      end
      s_tag_check: begin
        ctrl.tag_ren  = 1'b1;
        ctrl.data_ren = 1'b1;
      end
      s_access: begin
        if (is_init) begin
          ctrl.tag_wen  = 1'b1;
          ctrl.data_wen = 1'b1;
          ctrl.resp_en  = 1'b1;
        end else if (hit) begin
          ctrl.data_wen = is_write;
          ctrl.resp_en  = 1'b1;
        end
      end
      s_wait:          cacheresp_val = 1'b1;
      s_evict_prepare: ctrl.evict_addr_en = 1'b1;
      s_evict_request: begin
        memreq_val           = 1'b1;
        ctrl.mem_type        = cache_pkg::mem_write;
        ctrl.memreq_addr_sel = cache_pkg::sel_evict_addr;
      end
      s_evict_wait:     memresp_rdy = 1'b1;
      s_refill_request: memreq_val = 1'b1;
      s_refill_wait: begin
        memresp_rdy    = 1'b1;
        ctrl.refill_en = memresp_val;
      end
      s_refill_update: begin
        ctrl.tag_wen   = 1'b1;
        ctrl.data_wen  = 1'b1;
        ctrl.write_sel = cache_pkg::sel_refill;
      end
      default: begin
        cachereq_rdy = 1'b0;
      end
    endcase
  end

  // ------------------------------
  // Valid and dirty bits
  // ------------------------------

  // Init validates the line but leaves dirty alone
  assign set_valid   = (state == s_access && is_init) || (state == s_refill_update);
  assign set_dirty   = (state == s_access) && is_write && hit;
  assign clear_dirty = (state == s_refill_update);

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (set_valid) begin
        valid_bits[idx] <= 1'b1;
      end
      if (set_dirty) begin
        dirty_bits[idx] <= 1'b1;
      end else if (clear_dirty) begin
        dirty_bits[idx] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache_req_in.sv ====
// Cache request input stage
// Holds the accepted request and derives index and word byte enables
`timescale 1ns/100ps
`default_nettype none

module cache_req_in #(
  parameter int num_lines = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  cache_pkg::cache_req_t cachereq,
  cache_ctrl_if.dpath           ctrl,
  output cache_pkg::cache_req_t req_reg,
  output logic [15:0]           wben
);

  localparam int index_nbits = $clog2(num_lines);

  // Request is held for the whole transaction, misses included
  always_ff @(posedge clk) begin
    if (reset) begin
      req_reg <= '0;
    end else if (ctrl.req_en) begin
      req_reg <= cachereq;
    end
  end

  assign ctrl.req_type  = req_reg.msg_type;
  assign ctrl.req_index = req_reg.addr[cache_pkg::offset_nbits +: index_nbits];

  // One nibble of byte enables per word
  always_comb begin
    wben = '0;
    wben[4*cache_pkg::word_sel(req_reg.addr) +: 4] = 4'hf;
  end

endmodule

`default_nettype wire

// ==== cache_ctrl_if.sv ====
// Controller to datapath bundle
// Strobes out of the cache FSM, request status back into it
`timescale 1ns/100ps
`default_nettype none

interface cache_ctrl_if #(
  parameter int num_lines = 16
);

  localparam int index_nbits = $clog2(num_lines);

  // Strobes from the controller
  logic                   req_en;
  logic                   tag_ren;
  logic                   tag_wen;
  logic                   data_ren;
  logic                   data_wen;
  logic                   write_sel;
  logic                   evict_addr_en;
  logic                   memreq_addr_sel;
  logic                   refill_en;
  logic                   resp_en;
  cache_pkg::mem_type_t   mem_type;

  // Status from the datapath
  logic                   tag_match;
  cache_pkg::req_type_t   req_type;
  logic [index_nbits-1:0] req_index;

  modport ctrl (
    output req_en, tag_ren, tag_wen, data_ren, data_wen, write_sel,
    output evict_addr_en, memreq_addr_sel, refill_en, resp_en, mem_type,
    input  tag_match, req_type, req_index
  );

  modport dpath (
    input  req_en, tag_ren, tag_wen, data_ren, data_wen, write_sel,
    input  evict_addr_en, memreq_addr_sel, refill_en, resp_en, mem_type,
    output tag_match, req_type, req_index
  );

endinterface

`default_nettype wire

// ==== cache_pkg.sv ====
// Cache message package
// Widths, request and memory message types, address field helpers
`default_nettype none

package cache_pkg;

  localparam int addr_nbits   = 32;
  localparam int data_nbits   = 32;
  localparam int line_nbits   = 128;
  localparam int opaque_nbits = 8;
  // Byte offset bits within a 16-byte line
  localparam int offset_nbits = 4;
  localparam int line_words   = line_nbits / data_nbits;
  localparam int line_bytes   = line_nbits / 8;

  // Datapath select encodings
  localparam logic sel_req_word    = 1'b0;
  localparam logic sel_refill      = 1'b1;
  localparam logic sel_evict_addr  = 1'b0;
  localparam logic sel_refill_addr = 1'b1;

  typedef enum logic [2:0] {
    req_read  = 3'd0,
    req_write = 3'd1,
    req_init  = 3'd2
  } req_type_t;

  typedef struct packed {
    req_type_t               msg_type;
    logic [opaque_nbits-1:0] opaque;
    logic [addr_nbits-1:0]   addr;
    logic [data_nbits-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    req_type_t               msg_type;
    logic [opaque_nbits-1:0] opaque;
    logic [data_nbits-1:0]   data;
  } cache_resp_t;

  typedef enum logic {
    mem_read  = 1'b0,
    mem_write = 1'b1
  } mem_type_t;

  typedef struct packed {
    mem_type_t             msg_type;
    logic [addr_nbits-1:0] addr;
    logic [line_nbits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    mem_type_t             msg_type;
    logic [line_nbits-1:0] data;
  } mem_resp_t;

  // Word within the line, two bits for four words
  function automatic logic [1:0] word_sel(logic [addr_nbits-1:0] addr);
    return addr[3:2];
  endfunction

  function automatic logic [addr_nbits-1:0] line_base(logic [addr_nbits-1:0] addr);
    return {addr[addr_nbits-1:offset_nbits], {offset_nbits{1'b0}}};
  endfunction

endpackage

`default_nettype wire
